// ==== qla_regbus.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/board_pkg.sv
verilog/bus_arbiter.sv
verilog/reg_decode.sv
verilog/hub_mem.sv
verilog/axis_ctrl.sv
verilog/board_regs.sv
verilog/qla_regbus_top.sv
sim/qla_regbus_props.sv
sim/tb_qla_regbus.sv

// ==== Makefile ====
# Verilator build and run for qla_regbus

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_qla_regbus
FILELIST = qla_regbus.f
OBJ_DIR  = obj_dir
LOG      = sim.log
SIM_ARGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_qla_regbus.sv ====
// qla register bus testbench
`default_nettype none
`timescale 1ns/1ps

`include "qla_defines.svh"

module tb_qla_regbus;

    localparam int ACK_TIMEOUT  = 50;       // cycles per host access
    localparam int TRIP_TIMEOUT = 100;      // cycles for a safety trip
    localparam int ROUNDS       = 24;       // contention rounds

    logic                   sysclk;
    logic                   rst_n;
    bus_pkg::wb_req_t       fw_req;
    bus_pkg::wb_req_t       eth_req;
    bus_pkg::wb_rsp_t       fw_rsp;
    bus_pkg::wb_rsp_t       eth_rsp;
    board_pkg::axis_word_t  cur_fb;
    logic [3:0]             board_id;
    board_pkg::axis_word_t  dac_cmd;
    logic                   pwr_enable;
    board_pkg::axis_mask_t  amp_enable;

    int                     value_errors;
    int                     timeouts;
    logic [`QLA_DATA_W-1:0] hub_model [`QLA_HUB_DEPTH];    // last word written

    qla_regbus_top dut (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .fw_req     (fw_req),
        .eth_req    (eth_req),
        .cur_fb     (cur_fb),
        .board_id   (board_id),
        .fw_rsp     (fw_rsp),
        .eth_rsp    (eth_rsp),
        .dac_cmd    (dac_cmd),
        .pwr_enable (pwr_enable),
        .amp_enable (amp_enable)
    );

    initial sysclk = 1'b0;
    always #5 sysclk = ~sysclk;             // 10 ns

    // --------------------
    // address and status helpers
    function automatic logic [`QLA_ADDR_W-1:0] hub_addr(input logic [`QLA_HUB_AW-1:0] idx);
        return {`QLA_REGION_HUB, 12'(idx)};
    endfunction

    function automatic logic [`QLA_ADDR_W-1:0] chan_addr(input logic [3:0] chan,
                                                         input logic [3:0] off);
        return {`QLA_REGION_BOARD, 4'd0, chan, off};
    endfunction

    // status word as the register map lays it out
    function automatic logic [`QLA_DATA_W-1:0] status_word(input logic pwr,
                                                           input logic [3:0] safety,
                                                           input logic [3:0] amp);
        logic [`QLA_DATA_W-1:0] w;
        w                = '0;
        w[27:24]         = board_id;
        w[`QLA_PWR_BIT]  = pwr;
        w[11:8]          = safety;
        w[3:0]           = amp;         // effective enables
        return w;
    endfunction

    task automatic expect_equal(input logic [`QLA_DATA_W-1:0] got,
                                input logic [`QLA_DATA_W-1:0] exp, input string what);
        assert (got === exp)
        else begin
            value_errors++;
            $display("Fail %0t: %s read %h expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------
    // one wishbone cycle per host port
    task automatic fw_cycle(input logic we, input logic [`QLA_ADDR_W-1:0] adr,
                            input logic [`QLA_DATA_W-1:0] wdat,
                            output logic [`QLA_DATA_W-1:0] rdat);
        int waited;
        waited = 0;
        rdat   = '0;
        @(negedge sysclk);
        fw_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(negedge sysclk);
            waited++;
        end while (!fw_rsp.ack && waited < ACK_TIMEOUT);
        if (fw_rsp.ack)
            rdat = fw_rsp.dat;
        else begin
            timeouts++;
            $display("timeout at %0t: firewire port got no ack for address %h", $time, adr);
        end
        @(negedge sysclk);                  // hold through the ack edge
        fw_req = '0;
    endtask

    task automatic eth_cycle(input logic we, input logic [`QLA_ADDR_W-1:0] adr,
                             input logic [`QLA_DATA_W-1:0] wdat,
                             output logic [`QLA_DATA_W-1:0] rdat);
        int waited;
        waited = 0;
        rdat   = '0;
        @(negedge sysclk);
        eth_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(negedge sysclk);
            waited++;
        end while (!eth_rsp.ack && waited < ACK_TIMEOUT);
        if (eth_rsp.ack)
            rdat = eth_rsp.dat;
        else begin
            timeouts++;
            $display("timeout at %0t: ethernet port got no ack for address %h", $time, adr);
        end
        @(negedge sysclk);
        eth_req = '0;
    endtask

    // --------------------
    // stimulus
    initial begin
        logic [`QLA_DATA_W-1:0] rd;
        logic [`QLA_DATA_W-1:0] rd_f;
        logic [`QLA_DATA_W-1:0] rd_e;
        logic [`QLA_DATA_W-1:0] wd_f;
        logic [`QLA_DATA_W-1:0] wd_e;
        logic [`QLA_DATA_W-1:0] pwr_amp;
        logic [`QLA_HUB_AW-1:0] idx_f;
        logic [`QLA_HUB_AW-1:0] idx_e;
        logic [`QLA_CMD_W-1:0]  cmd;
        int                     waited;
        int unsigned            prop_errors;

        void'($urandom(32'ha1af_739c));
        value_errors = 0;
        timeouts     = 0;
        rst_n        = 1'b0;
        fw_req       = '0;
        eth_req      = '0;
        cur_fb       = '0;
        board_id     = 4'ha;
        pwr_amp      = (32'd1 << `QLA_PWR_BIT) | 32'hf;     // power + all amps
        repeat (5) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        // hub words across the two ports
        for (int i = 0; i < 16; i++) begin
            idx_f = `QLA_HUB_AW'($urandom);
            wd_f  = $urandom;
            if (i % 2 == 0) begin
                fw_cycle(1'b1, hub_addr(idx_f), wd_f, rd);
                eth_cycle(1'b0, hub_addr(idx_f), '0, rd);
            end else begin
                eth_cycle(1'b1, hub_addr(idx_f), wd_f, rd);
                fw_cycle(1'b0, hub_addr(idx_f), '0, rd);
            end
            hub_model[idx_f] = wd_f;
            expect_equal(rd, wd_f, "hub word");
        end

        // dac commands, channel a+1
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            cmd = `QLA_CMD_W'($urandom);
            fw_cycle(1'b1, chan_addr(4'(a + 1), `QLA_OFF_DAC_CMD), `QLA_DATA_W'(cmd), rd);
            eth_cycle(1'b0, chan_addr(4'(a + 1), `QLA_OFF_DAC_CMD), '0, rd);
            expect_equal(rd, `QLA_DATA_W'(cmd), "dac command");
            expect_equal(`QLA_DATA_W'(dac_cmd[a]), `QLA_DATA_W'(cmd), "dac_cmd port");
        end

        // both hosts on the same edge, distinct words
        for (int r = 0; r < ROUNDS; r++) begin
            idx_f = `QLA_HUB_AW'($urandom);
            idx_e = idx_f ^ `QLA_HUB_AW'(1 + $urandom % 63);
            wd_f  = $urandom;
            wd_e  = $urandom;
            fork
                fw_cycle(1'b1, hub_addr(idx_f), wd_f, rd_f);
                eth_cycle(1'b1, hub_addr(idx_e), wd_e, rd_e);
            join
            hub_model[idx_f] = wd_f;
            hub_model[idx_e] = wd_e;
            fork
                fw_cycle(1'b0, hub_addr(idx_e), '0, rd_f);
                eth_cycle(1'b0, hub_addr(idx_f), '0, rd_e);
            join
            expect_equal(rd_f, hub_model[idx_e], "hub word, firewire");
            expect_equal(rd_e, hub_model[idx_f], "hub word, ethernet");
        end

        // status register
        fw_cycle(1'b1, chan_addr(4'd0, `QLA_OFF_STATUS), pwr_amp, rd);
        eth_cycle(1'b0, chan_addr(4'd0, `QLA_OFF_STATUS), '0, rd);
        expect_equal(rd, status_word(1'b1, 4'h0, 4'hf), "status");
        expect_equal(32'(pwr_enable), 32'd1, "pwr_enable port");
        expect_equal(32'(amp_enable), 32'hf, "amp_enable port");

        // --------------------
        // axis 2 over-current trip
        cmd = 16'd100;
        fw_cycle(1'b1, chan_addr(4'd2, `QLA_OFF_DAC_CMD), `QLA_DATA_W'(cmd), rd);
        cur_fb[1] = 16'd201;                // just above 2x
        waited    = 0;
        while (amp_enable[1] && waited < TRIP_TIMEOUT) begin
            @(negedge sysclk);
            waited++;
        end
        if (amp_enable[1]) begin
            timeouts++;
            $display("timeout at %0t: axis 2 amplifier never tripped", $time);
        end
        eth_cycle(1'b0, chan_addr(4'd2, `QLA_OFF_CUR_FB), '0, rd);
        expect_equal(rd, 32'd201, "feedback current");
        fw_cycle(1'b0, chan_addr(4'd0, `QLA_OFF_STATUS), '0, rd);
        expect_equal(rd, status_word(1'b1, 4'b0010, 4'b1101), "status after trip");
        expect_equal(32'(amp_enable), 32'hd, "amp_enable after trip");

        cur_fb[1] = 16'd150;                // back under the limit
        eth_cycle(1'b1, chan_addr(4'd0, `QLA_OFF_STATUS), 32'hf, rd);    // amp bits alone
        fw_cycle(1'b0, chan_addr(4'd0, `QLA_OFF_STATUS), '0, rd);
        expect_equal(rd, status_word(1'b0, 4'b0000, 4'b1111), "status after re-arm");
        expect_equal(32'(pwr_enable), 32'd0, "pwr_enable after re-arm");
        expect_equal(32'(amp_enable), 32'hf, "amp_enable after re-arm");

        // unmapped regions and channel 5
        for (int r = 2; r < 16; r++) begin
            if (r % 2 == 0)
                fw_cycle(1'b0, {4'(r), 12'($urandom)}, '0, rd);
            else
                eth_cycle(1'b0, {4'(r), 12'($urandom)}, '0, rd);
            expect_equal(rd, '0, "unmapped region");
        end
        eth_cycle(1'b0, chan_addr(4'd5, `QLA_OFF_DAC_CMD), '0, rd);
        expect_equal(rd, '0, "channel 5");

        // --------------------
        // summary
        prop_errors = dut.props.fail_count;
        $display("summary: %0d value errors, %0d timeouts, %0d property failures",
                 value_errors, timeouts, prop_errors);
        if (value_errors == 0 && timeouts == 0 && prop_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/qla_regbus_props.sv ====
// bus protocol assertions
`default_nettype none
`timescale 1ns/1ps

module qla_regbus_props (
    input wire                   sysclk,
    input wire                   rst_n,
    input wire bus_pkg::wb_req_t fw_req,
    input wire bus_pkg::wb_req_t eth_req,
    input wire bus_pkg::wb_rsp_t fw_rsp,
    input wire bus_pkg::wb_rsp_t eth_rsp,
    input wire [1:0]             grant      // arbiter grant register
);

    int unsigned fail_count = 0;

    // --------------------
    // arbiter
    grant_onehot: assert property (@(posedge sysclk) disable iff (!rst_n) $onehot0(grant))
        else begin
            fail_count++;
            $error("both hosts granted");
        end

    // ack only inside the owner's cycle
    fw_ack_in_cyc: assert property (@(posedge sysclk) disable iff (!rst_n)
        fw_rsp.ack |-> fw_req.cyc)
        else begin
            fail_count++;
            $error("firewire ack outside its cycle");
        end

    eth_ack_in_cyc: assert property (@(posedge sysclk) disable iff (!rst_n)
        eth_rsp.ack |-> eth_req.cyc)
        else begin
            fail_count++;
            $error("ethernet ack outside its cycle");
        end

    // --------------------
    // single-cycle ack
    fw_ack_single: assert property (@(posedge sysclk) disable iff (!rst_n)
        fw_rsp.ack |=> !fw_rsp.ack)
        else begin
            fail_count++;
            $error("firewire ack held two cycles");
        end

    eth_ack_single: assert property (@(posedge sysclk) disable iff (!rst_n)
        eth_rsp.ack |=> !eth_rsp.ack)
        else begin
            fail_count++;
            $error("ethernet ack held two cycles");
        end

    // stb held until ack
    fw_stb_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (fw_req.stb && !fw_rsp.ack) |=> fw_req.stb)
        else begin
            fail_count++;
            $error("firewire stb dropped before ack");
        end

    eth_stb_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (eth_req.stb && !eth_rsp.ack) |=> eth_req.stb)
        else begin
            fail_count++;
            $error("ethernet stb dropped before ack");
        end

    // both hosts quiet while reset is held
    no_ack_in_reset: assert property (@(posedge sysclk)
        !rst_n |-> !(fw_rsp.ack || eth_rsp.ack))
        else begin
            fail_count++;
            $error("ack seen during reset");
        end

endmodule

bind qla_regbus_top qla_regbus_props props (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .fw_req  (fw_req),
    .eth_req (eth_req),
    .fw_rsp  (fw_rsp),
    .eth_rsp (eth_rsp),
    .grant   (arb.grant)
);

`default_nettype wire

// ==== verilog/qla_regbus_top.sv ====
// qla register bus top level
`default_nettype none
`timescale 1ns/1ps

module qla_regbus_top (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire bus_pkg::wb_req_t      fw_req,      // firewire host port
    input  wire bus_pkg::wb_req_t      eth_req,     // ethernet host port
    input  wire board_pkg::axis_word_t cur_fb,      // feedback currents
    input  wire [3:0]                  board_id,
    output bus_pkg::wb_rsp_t           fw_rsp,
    output bus_pkg::wb_rsp_t           eth_rsp,
    output board_pkg::axis_word_t      dac_cmd,
    output logic                       pwr_enable,
    output board_pkg::axis_mask_t      amp_enable
);

    // --------------------
    // shared bus and slave ports
    bus_pkg::wb_req_t      bus_req;
    bus_pkg::wb_rsp_t      bus_rsp;
    bus_pkg::wb_req_t      hub_req;
    bus_pkg::wb_rsp_t      hub_rsp;
    bus_pkg::wb_req_t      board_req;
    bus_pkg::wb_rsp_t      board_rsp;
    bus_pkg::wb_req_t      axis_req;
    bus_pkg::wb_rsp_t      axis_rsp;

    // side band between chan0 and axes
    board_pkg::axis_mask_t safety_disable;
    board_pkg::axis_mask_t clear_disable;

    bus_arbiter arb (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .fw_req  (fw_req),
        .eth_req (eth_req),
        .bus_rsp (bus_rsp),
        .fw_rsp  (fw_rsp),
        .eth_rsp (eth_rsp),
        .bus_req (bus_req)
    );

    reg_decode dec (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .hub_rsp   (hub_rsp),
        .board_rsp (board_rsp),
        .axis_rsp  (axis_rsp),
        .bus_rsp   (bus_rsp),
        .hub_req   (hub_req),
        .board_req (board_req),
        .axis_req  (axis_req)
    );

    hub_mem hub (.sysclk(sysclk), .rst_n(rst_n), .req(hub_req), .rsp(hub_rsp));

    // --------------------
    // axes 1..4
    axis_ctrl axis (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .req            (axis_req),
        .cur_fb         (cur_fb),
        .clear_disable  (clear_disable),
        .rsp            (axis_rsp),
        .dac_cmd        (dac_cmd),
        .safety_disable (safety_disable)
    );

    board_regs chan0 (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .req            (board_req),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .rsp            (board_rsp),
        .pwr_enable     (pwr_enable),
        .amp_enable     (amp_enable),
        .clear_disable  (clear_disable)
    );

endmodule

`default_nettype wire

// ==== verilog/board_regs.sv ====
// channel-0 board register
`default_nettype none
`timescale 1ns/1ps

`include "qla_defines.svh"

module board_regs (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire bus_pkg::wb_req_t      req,
    input  wire [3:0]                  board_id,        // rotary switch
    input  wire board_pkg::axis_mask_t safety_disable,
    output bus_pkg::wb_rsp_t           rsp,
    output logic                       pwr_enable,
    output board_pkg::axis_mask_t      amp_enable,      // after safety mask
    output board_pkg::axis_mask_t      clear_disable    // one-cycle pulse
);

    bus_pkg::reg_addr_u     addr;
    logic                   access;
    logic                   status_wr;
    logic                   ack;
    board_pkg::axis_mask_t  amp_cmd;    // as written by host
    logic [`QLA_DATA_W-1:0] status;
    logic [`QLA_DATA_W-1:0] rdata;

    assign addr       = req.adr;
    assign access     = req.stb & ~ack;
    assign status_wr  = access & req.we & (addr.board.offset == `QLA_OFF_STATUS);
    assign amp_enable = amp_cmd & ~safety_disable;  // tripped axes off

    // --------------------
    // status word
    always_comb begin
        status                      = '0;
        status[27:24]               = board_id;
        status[`QLA_PWR_BIT]        = pwr_enable;
        status[8 +: `QLA_NUM_AXES]  = safety_disable;
        status[0 +: `QLA_NUM_AXES]  = amp_enable;   // effective enables
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ack           <= 1'b0;
            pwr_enable    <= 1'b0;
            amp_cmd       <= '0;
            clear_disable <= '0;
        end else begin
            ack           <= access;
            clear_disable <= '0;
            if (status_wr) begin
                pwr_enable    <= req.dat[`QLA_PWR_BIT];
                amp_cmd       <= req.dat[`QLA_NUM_AXES-1:0];
                // power bit re-arms every axis
                clear_disable <= {`QLA_NUM_AXES{req.dat[`QLA_PWR_BIT]}}
                               | req.dat[`QLA_NUM_AXES-1:0];
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (access)
            rdata <= (addr.board.offset == `QLA_OFF_STATUS) ? status : '0;
    end

    assign rsp = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

// ==== verilog/axis_ctrl.sv ====
// axis dac commands and safety check
`default_nettype none
`timescale 1ns/1ps

`include "qla_defines.svh"

module axis_ctrl (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire bus_pkg::wb_req_t      req,
    input  wire board_pkg::axis_word_t cur_fb,          // feedback currents
    input  wire board_pkg::axis_mask_t clear_disable,   // pulse from chan0
    output bus_pkg::wb_rsp_t           rsp,
    output board_pkg::axis_word_t      dac_cmd,
    output board_pkg::axis_mask_t      safety_disable   // tripped axes
);

    localparam int               CNT_W   = $clog2(`QLA_SAFETY_CNT + 1);
    localparam int               IDX_W   = $clog2(`QLA_NUM_AXES);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`QLA_SAFETY_CNT);

    bus_pkg::reg_addr_u       addr;
    logic [IDX_W-1:0]         axis_idx;
    logic                     access;
    logic                     ack;
    logic [`QLA_DATA_W-1:0]   rdata;
    logic [`QLA_NUM_AXES-1:0] over;                     // fb above 2x cmd
    logic [CNT_W-1:0]         over_cnt [`QLA_NUM_AXES];

    assign addr     = req.adr;
    assign axis_idx = IDX_W'(addr.board.chan - 4'd1);   // chan 1 is axis 0
    assign access   = req.stb & ~ack;

    // --------------------
    // register side
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            dac_cmd <= '0;
        end else begin
            ack <= access;
            if (access && req.we && addr.board.offset == `QLA_OFF_DAC_CMD)
                dac_cmd[axis_idx] <= req.dat[`QLA_CMD_W-1:0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (access) begin
            case (addr.board.offset)
                `QLA_OFF_CUR_FB:  rdata <= `QLA_DATA_W'(cur_fb[axis_idx]);
                `QLA_OFF_DAC_CMD: rdata <= `QLA_DATA_W'(dac_cmd[axis_idx]);
                default:          rdata <= '0;
            endcase
        end
    end

    assign rsp = '{ack: ack, dat: rdata};

    // --------------------
    // safety, one extra bit so 2x cmd cannot wrap
    always_comb begin
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            over[i] = {1'b0, cur_fb[i]} > {dac_cmd[i], 1'b0};
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            safety_disable <= '0;
            for (int i = 0; i < `QLA_NUM_AXES; i++)
                over_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (clear_disable[i]) begin
                    safety_disable[i] <= 1'b0;      // re-arm
                    over_cnt[i]       <= '0;
                end else begin
                    if (!over[i])
                        over_cnt[i] <= '0;          // must be consecutive
                    else if (over_cnt[i] != CNT_MAX)
                        over_cnt[i] <= over_cnt[i] + 1'b1;
                    if (over_cnt[i] == CNT_MAX)
                        safety_disable[i] <= 1'b1;  // sticky until clear
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hub_mem.sv ====
// hub memory slave
`default_nettype none
`timescale 1ns/1ps

`include "qla_defines.svh"

module hub_mem (
    input  wire                   sysclk,
    input  wire                   rst_n,
    input  wire bus_pkg::wb_req_t req,
    output bus_pkg::wb_rsp_t      rsp
);

    logic [`QLA_DATA_W-1:0] mem [`QLA_HUB_DEPTH];
    bus_pkg::reg_addr_u     addr;
    logic [`QLA_HUB_AW-1:0] idx;        // word index
    logic                   access;     // first cycle of stb
    logic                   ack;
    logic [`QLA_DATA_W-1:0] rdata;

    assign addr   = req.adr;
    assign idx    = addr.hub.offset[`QLA_HUB_AW-1:0];   // upper offset bits alias
    assign access = req.stb & ~ack;

    // storage and read data
    always_ff @(posedge sysclk) begin
        if (access && req.we)
            mem[idx] <= req.dat;
        if (access && !req.we)
            rdata <= mem[idx];          // lands with ack
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            ack <= 1'b0;
        else
            ack <= access;              // one cycle, then drops
    end

    assign rsp = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

// ==== verilog/reg_decode.sv ====
// register address decoder
`default_nettype none
`timescale 1ns/1ps

`include "qla_defines.svh"

module reg_decode (
    input  wire                   sysclk,
    input  wire                   rst_n,
    input  wire bus_pkg::wb_req_t bus_req,
    input  wire bus_pkg::wb_rsp_t hub_rsp,
    input  wire bus_pkg::wb_rsp_t board_rsp,
    input  wire bus_pkg::wb_rsp_t axis_rsp,
    output bus_pkg::wb_rsp_t      bus_rsp,
    output bus_pkg::wb_req_t      hub_req,
    output bus_pkg::wb_req_t      board_req,    // channel 0
    output bus_pkg::wb_req_t      axis_req      // channels 1..4
);

    bus_pkg::reg_addr_u addr;
    logic               sel_hub;
    logic               sel_board;
    logic               sel_axis;
    logic               sel_none;   // unmapped region or channel
    logic               nomap_ack;

    assign addr = bus_req.adr;

    // --------------------
    // region / channel select
    always_comb begin
        sel_hub   = (addr.hub.region == `QLA_REGION_HUB);
        sel_board = (addr.board.region == `QLA_REGION_BOARD) && (addr.board.chan == 4'd0);
        sel_axis  = (addr.board.region == `QLA_REGION_BOARD)
                 && (addr.board.chan >= 4'd1)
                 && (addr.board.chan <= 4'(`QLA_NUM_AXES));
        sel_none  = !(sel_hub || sel_board || sel_axis);
    end

    // only stb is qualified, rest fans out as is
    always_comb begin
        hub_req       = bus_req;
        board_req     = bus_req;
        axis_req      = bus_req;
        hub_req.stb   = bus_req.stb & sel_hub;
        board_req.stb = bus_req.stb & sel_board;
        axis_req.stb  = bus_req.stb & sel_axis;
    end

    // unmapped access still gets its ack, data reads zero
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            nomap_ack <= 1'b0;
        else
            nomap_ack <= bus_req.stb & sel_none & ~nomap_ack;
    end

    // --------------------
    // read mux keyed on ack, holds even if the host moves adr early
    always_comb begin
        bus_rsp.ack = hub_rsp.ack | board_rsp.ack | axis_rsp.ack | nomap_ack;
        bus_rsp.dat = ({`QLA_DATA_W{hub_rsp.ack}}   & hub_rsp.dat)
                    | ({`QLA_DATA_W{board_rsp.ack}} & board_rsp.dat)
                    | ({`QLA_DATA_W{axis_rsp.ack}}  & axis_rsp.dat);
    end

endmodule

`default_nettype wire

// ==== verilog/bus_arbiter.sv ====
// two-host bus arbiter
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter (
    input  wire                   sysclk,
    input  wire                   rst_n,
    input  wire bus_pkg::wb_req_t fw_req,     // firewire host
    input  wire bus_pkg::wb_req_t eth_req,    // ethernet host
    input  wire bus_pkg::wb_rsp_t bus_rsp,    // from decoder
    output bus_pkg::wb_rsp_t      fw_rsp,
    output bus_pkg::wb_rsp_t      eth_rsp,
    output bus_pkg::wb_req_t      bus_req     // shared bus
);

    localparam logic [1:0] GNT_NONE = 2'b00;
    localparam logic [1:0] GNT_FW   = 2'b01;
    localparam logic [1:0] GNT_ETH  = 2'b10;

    logic [1:0] grant;          // [0] fw, [1] eth, never both
    logic [1:0] grant_nxt;
    logic       last_fw;        // fw won the last grant
    logic       hold;           // granted host still in its cycle

    // --------------------
    // next grant
    always_comb begin
        hold      = (grant[0] & fw_req.cyc) | (grant[1] & eth_req.cyc);
        grant_nxt = grant;
        if (!hold) begin
            // releasing host has cyc low, so the waiting one gets the bus
            if (eth_req.cyc && (!fw_req.cyc || last_fw))
                grant_nxt = GNT_ETH;    // alone, or fw went last
            else if (fw_req.cyc)
                grant_nxt = GNT_FW;
            else
                grant_nxt = GNT_NONE;   // idle bus
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            grant   <= GNT_NONE;
            last_fw <= 1'b1;            // eth first out of reset
        end else begin
            grant <= grant_nxt;
            if (grant_nxt != GNT_NONE)
                last_fw <= grant_nxt[0];
        end
    end

    // --------------------
    // request onto the bus, ungranted host sees nothing
    always_comb begin
        case (grant)
            GNT_FW:  bus_req = fw_req;
            GNT_ETH: bus_req = eth_req;
            default: bus_req = '0;      // no stb while idle
        endcase
    end

    // response back to the owner only
    always_comb begin
        fw_rsp  = '0;
        eth_rsp = '0;
        if (grant[0])
            fw_rsp = bus_rsp;
        if (grant[1])
            eth_rsp = bus_rsp;
    end

endmodule

`default_nettype wire

// ==== verilog/board_pkg.sv ====
// per-axis board types
`default_nettype none

`include "qla_defines.svh"

package board_pkg;

    // --------------------
    // one word per axis, [0] is axis 1 (channel 1)
    typedef logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] axis_word_t;

    // one bit per axis, same order as above
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;

endpackage

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
// register bus types
`default_nettype none

`include "qla_defines.svh"

package bus_pkg;

    // --------------------
    // wishbone classic, host side
    typedef struct packed {
        logic                   cyc;    // bus cycle in progress
        logic                   stb;    // valid transfer
        logic                   we;     // 1 = write
        logic [`QLA_ADDR_W-1:0] adr;
        logic [`QLA_DATA_W-1:0] dat;    // write data
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic                   ack;    // exactly one cycle
        logic [`QLA_DATA_W-1:0] dat;    // read data, valid with ack
    } wb_rsp_t;

    // --------------------
    // two views of one 16-bit address
    typedef struct packed {
        logic [3:0]  region;    // addr[15:12]
        logic [11:0] offset;    // hub word index, low bits used
    } hub_addr_t;

    typedef struct packed {
        logic [3:0] region;
        logic [3:0] spare;      // ignored
        logic [3:0] chan;       // 0 = board, 1..4 = axes
        logic [3:0] offset;     // register within channel
    } board_addr_t;

    typedef union packed {
        hub_addr_t   hub;
        board_addr_t board;
    } reg_addr_u;

endpackage

`default_nettype wire

// ==== verilog/qla_defines.svh ====
// qla register bus parameters
`ifndef QLA_DEFINES_SVH
`define QLA_DEFINES_SVH

// --------------------
// bus widths
`define QLA_ADDR_W        16      // register address
`define QLA_DATA_W        32      // register data
`define QLA_CMD_W         16      // dac command and feedback current
`define QLA_NUM_AXES      4

// --------------------
// address map, addr[15:12]
`define QLA_REGION_BOARD  4'd0    // chan0 + axes
`define QLA_REGION_HUB    4'd1    // hub memory
`define QLA_HUB_DEPTH     64      // words
`define QLA_HUB_AW        6       // hub word index width

// register offsets, addr[3:0]
`define QLA_OFF_STATUS    4'd0    // chan0 status / enables
`define QLA_OFF_CUR_FB    4'd0    // axis feedback current, read only
`define QLA_OFF_DAC_CMD   4'd1    // axis dac command

// status word layout
`define QLA_PWR_BIT       16      // power enable

// consecutive over-current cycles before amp trip
`define QLA_SAFETY_CNT    4

`endif
